/* hdl/cw_target_cfg.svh */
`ifndef CW_TARGET_CFG_SVH
`define CW_TARGET_CFG_SVH

// register bus
`define CW_REG_ADDR_W       8
`define CW_REG_DATA_W       8

// external async SRAM
`define CW_SRAM_ADDR_W      12
`define CW_SRAM_DATA_W      16
`define CW_SRAM_BLOCK_W     4   // words per top_addr unit = 2**4

// heartbeat counter, MSB drives LED 0
`define CW_HB_BITS          25

`define CW_TARGET_ID        8'h41

// register map
`define REG_ID              8'h00
`define REG_DIPS            8'h01
`define REG_LED_CTRL        8'h02   // bit 0 test mode, bit 1 flash all
`define REG_TEST_LEDS       8'h03
`define REG_SRAM_CTRL       8'h04   // bit 0 enable
`define REG_SRAM_TOP        8'h05
`define REG_SRAM_WWAIT      8'h06
`define REG_SRAM_RWAIT      8'h07
`define REG_SRAM_STATUS     8'h08   // bit 0 pass, bit 1 fail
`define REG_SRAM_RUNS       8'h09   // low byte of run counter

`endif

/* hdl/cw_target_pkg.sv */
`default_nettype none

`include "cw_target_cfg.svh"

package cw_target_pkg;

    // register bus
    typedef logic [`CW_REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`CW_REG_DATA_W-1:0]  reg_data_t;

    // SRAM side
    typedef logic [`CW_SRAM_ADDR_W-1:0] sram_addr_t;
    typedef logic [`CW_SRAM_DATA_W-1:0] sram_data_t;

    typedef logic [7:0]                 wait_cnt_t;  // extra strobe cycles
    typedef logic [15:0]                run_cnt_t;   // completed passes
    typedef logic [7:0]                 led_vec_t;

    // SRAM tester FSM
    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        WRITE_GAP,
        READ,
        CHECK,
        DONE
    } sram_state_e;

endpackage

`default_nettype wire

/* hdl/cw_target_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// control and status between register bank and SRAM tester
interface sram_test_if import cw_target_pkg::*; ();

    logic       enable;
    reg_data_t  top_addr;    // last block to test
    wait_cnt_t  write_wait;
    wait_cnt_t  read_wait;
    logic       pass;        // sticky
    logic       fail;        // sticky
    run_cnt_t   runs;

    modport ctrl   (output enable, top_addr, write_wait, read_wait,
                    input  pass, fail, runs);
    modport tester (input  enable, top_addr, write_wait, read_wait,
                    output pass, fail, runs);

endinterface

// LED mode and status sources
interface led_ctrl_if import cw_target_pkg::*; ();

    logic       test_mode;
    logic       flash_all;
    led_vec_t   test_leds;
    logic       sram_en;
    logic       sram_pass;
    logic       sram_fail;

    modport ctrl (output test_mode, flash_all, test_leds,
                  output sram_en, sram_pass, sram_fail);
    modport disp (input  test_mode, flash_all, test_leds,
                  input  sram_en, sram_pass, sram_fail);

endinterface

`default_nettype wire

/* hdl/host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cw_target_cfg.svh"

module host_regs import cw_target_pkg::*; (
    input  logic        ext_clk,
    input  logic        rst_n_i,
    input  reg_addr_t   reg_addr_i,
    input  reg_data_t   reg_wdata_i,
    input  logic        reg_write_i,
    input  logic        reg_read_i,
    output reg_data_t   reg_rdata_o,
    input  reg_data_t   usr_dip_i,
    sram_test_if.ctrl   sram_o,
    led_ctrl_if.ctrl    led_o
);

    logic       test_mode;
    logic       flash_all;
    led_vec_t   test_leds;
    logic       sram_en;
    reg_data_t  sram_top;
    wait_cnt_t  write_wait;
    wait_cnt_t  read_wait;
    reg_data_t  rd_mux;

    // register writes, take effect on the next edge
    always_ff @(posedge ext_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            test_mode  <= 1'b0;
            flash_all  <= 1'b0;
            test_leds  <= '0;
            sram_en    <= 1'b0;
            sram_top   <= '0;
            write_wait <= '0;
            read_wait  <= '0;
        end else if (reg_write_i) begin
            case (reg_addr_i)
                `REG_LED_CTRL: begin
                    test_mode <= reg_wdata_i[0];
                    flash_all <= reg_wdata_i[1];
                end
                `REG_TEST_LEDS:  test_leds  <= reg_wdata_i;
                `REG_SRAM_CTRL:  sram_en    <= reg_wdata_i[0];
                `REG_SRAM_TOP:   sram_top   <= reg_wdata_i;
                `REG_SRAM_WWAIT: write_wait <= reg_wdata_i;
                `REG_SRAM_RWAIT: read_wait  <= reg_wdata_i;
                default: ;  // read-only or unmapped
            endcase
        end
    end

    // readback selection
    always_comb begin
        case (reg_addr_i)
            `REG_ID:          rd_mux = `CW_TARGET_ID;
            `REG_DIPS:        rd_mux = usr_dip_i;
            `REG_LED_CTRL:    rd_mux = {6'b0, flash_all, test_mode};
            `REG_TEST_LEDS:   rd_mux = test_leds;
            `REG_SRAM_CTRL:   rd_mux = {7'b0, sram_en};
            `REG_SRAM_TOP:    rd_mux = sram_top;
            `REG_SRAM_WWAIT:  rd_mux = write_wait;
            `REG_SRAM_RWAIT:  rd_mux = read_wait;
            `REG_SRAM_STATUS: rd_mux = {6'b0, sram_o.fail, sram_o.pass};
            `REG_SRAM_RUNS:   rd_mux = sram_o.runs[7:0];
            default:          rd_mux = '0;
        endcase
    end

    // read data is captured on the strobe and held until the next read
    always_ff @(posedge ext_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_rdata_o <= '0;
        end else if (reg_read_i) begin
            reg_rdata_o <= rd_mux;
        end
    end

    assign sram_o.enable     = sram_en;
    assign sram_o.top_addr   = sram_top;
    assign sram_o.write_wait = write_wait;
    assign sram_o.read_wait  = read_wait;

    assign led_o.test_mode = test_mode;
    assign led_o.flash_all = flash_all;
    assign led_o.test_leds = test_leds;
    assign led_o.sram_en   = sram_en;
    assign led_o.sram_pass = sram_o.pass;   // status straight from tester
    assign led_o.sram_fail = sram_o.fail;

    // host never issues both strobes in one cycle
    a_strobe_excl: assert property (
        @(posedge ext_clk) disable iff (!rst_n_i)
        !(reg_read_i && reg_write_i)
    );

endmodule

`default_nettype wire

/* hdl/sram_rwtest.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cw_target_cfg.svh"

module sram_rwtest import cw_target_pkg::*; (
    input  logic        ext_clk,
    input  logic        rst_n_i,
    sram_test_if.tester test_i,
    output sram_addr_t  sram_addr_o,
    output sram_data_t  sram_wdata_o,
    input  sram_data_t  sram_rdata_i,
    output logic        sram_cs_n_o,
    output logic        sram_we_n_o,
    output logic        sram_oe_n_o
);

    sram_state_e state;
    wait_cnt_t   wait_cnt;
    sram_addr_t  addr;
    sram_addr_t  last_addr;
    sram_data_t  pattern;
    sram_data_t  rd_q;
    run_cnt_t    runs;
    logic        pass;
    logic        fail;
    logic        mismatch;     // error seen in the current pass
    logic        en_d;

    assign last_addr = {test_i.top_addr, {`CW_SRAM_BLOCK_W{1'b1}}};
    assign pattern   = sram_data_t'(addr) ^ {`CW_SRAM_DATA_W{runs[0]}};

    always_ff @(posedge ext_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= IDLE;
            wait_cnt <= '0;
            addr     <= '0;
            runs     <= '0;
            pass     <= 1'b0;
            fail     <= 1'b0;
            mismatch <= 1'b0;
            en_d     <= 1'b0;
        end else begin
            en_d <= test_i.enable;
            case (state)
                IDLE: begin
                    if (test_i.enable) begin
                        addr     <= '0;
                        wait_cnt <= '0;
                        mismatch <= 1'b0;
                        state    <= WRITE;
                    end
                end
                WRITE: begin
                    if (wait_cnt == test_i.write_wait) begin
                        wait_cnt <= '0;
                        state    <= WRITE_GAP;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                WRITE_GAP: begin
                    if (!test_i.enable) begin
                        state <= IDLE;
                    end else if (addr == last_addr) begin
                        addr  <= '0;        // start read-back
                        state <= READ;
                    end else begin
                        addr  <= addr + 1'b1;
                        state <= WRITE;
                    end
                end
                READ: begin
                    if (wait_cnt == test_i.read_wait) begin
                        wait_cnt <= '0;
                        state    <= CHECK;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                CHECK: begin
                    if (rd_q != pattern) begin
                        mismatch <= 1'b1;
                        fail     <= 1'b1;
                    end
                    if (!test_i.enable) begin
                        state <= IDLE;
                    end else if (addr == last_addr) begin
                        state <= DONE;
                    end else begin
                        addr  <= addr + 1'b1;
                        state <= READ;
                    end
                end
                DONE: begin
                    runs <= runs + 1'b1;
                    if (!mismatch) pass <= 1'b1;
                    addr     <= '0;
                    mismatch <= 1'b0;
                    state    <= test_i.enable ? WRITE : IDLE;
                end
                default: state <= IDLE;
            endcase
            // fresh enable starts a new result set
            if (test_i.enable && !en_d) begin
                runs <= '0;
                pass <= 1'b0;
                fail <= 1'b0;
            end
        end
    end

    // sample at the end of the read strobe window
    always_ff @(posedge ext_clk) begin
        if (state == READ && wait_cnt == test_i.read_wait) rd_q <= sram_rdata_i;
    end

    assign sram_addr_o  = addr;
    assign sram_wdata_o = (state == WRITE) ? pattern : '0;
    assign sram_cs_n_o  = !(state == WRITE || state == READ);
    assign sram_we_n_o  = !(state == WRITE);
    assign sram_oe_n_o  = !(state == READ);

    assign test_i.pass = pass;
    assign test_i.fail = fail;
    assign test_i.runs = runs;

    // no read strobe during a write or in the cycle before it
    a_we_oe_excl: assert property (
        @(posedge ext_clk) disable iff (!rst_n_i)
        !sram_we_n_o |-> sram_oe_n_o && $past(sram_oe_n_o)
    );
    // a word keeps its address for the whole strobe
    a_cs_with_strobe: assert property (
        @(posedge ext_clk) disable iff (!rst_n_i)
        (!sram_we_n_o || !sram_oe_n_o) |->
            !sram_cs_n_o && ($past(sram_cs_n_o) || $stable(sram_addr_o))
    );

endmodule

`default_nettype wire

/* hdl/led_status.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cw_target_cfg.svh"

module led_status import cw_target_pkg::*; (
    input  logic        ext_clk,
    input  logic        rst_n_i,
    led_ctrl_if.disp    led_i,
    output led_vec_t    usr_led_o
);

    logic [`CW_HB_BITS-1:0] hb_cnt;

    // free-running heartbeat
    always_ff @(posedge ext_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    always_comb begin
        if (led_i.test_mode) begin
            if (led_i.flash_all) begin
                usr_led_o = {8{hb_cnt[`CW_HB_BITS-2]}};  // twice the heartbeat rate
            end else begin
                usr_led_o = led_i.test_leds;
            end
        end else begin
            // normal mode shows status
            usr_led_o    = '0;
            usr_led_o[0] = hb_cnt[`CW_HB_BITS-1];
            usr_led_o[1] = led_i.sram_en;
            usr_led_o[2] = led_i.sram_pass && !led_i.sram_fail;
            usr_led_o[3] = led_i.sram_fail;
        end
    end

endmodule

`default_nettype wire

/* hdl/cw_target_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cw_target_cfg.svh"

module cw_target_top (
    input  logic                        ext_clk,
    input  logic                        rst_n_i,

    // host register bus
    input  logic [`CW_REG_ADDR_W-1:0]   reg_addr_i,
    input  logic [`CW_REG_DATA_W-1:0]   reg_wdata_i,
    input  logic                        reg_write_i,
    input  logic                        reg_read_i,
    output logic [`CW_REG_DATA_W-1:0]   reg_rdata_o,

    // board I/O
    input  logic [7:0]                  usr_dip_i,
    output logic [7:0]                  usr_led_o,

    // async SRAM, data split into in and out
    output logic [`CW_SRAM_ADDR_W-1:0]  sram_addr_o,
    output logic [`CW_SRAM_DATA_W-1:0]  sram_wdata_o,
    input  logic [`CW_SRAM_DATA_W-1:0]  sram_rdata_i,
    output logic                        sram_cs_n_o,
    output logic                        sram_we_n_o,
    output logic                        sram_oe_n_o
);

    sram_test_if sram_bus ();
    led_ctrl_if  led_bus ();

    host_regs u_host_regs (
        .ext_clk        (ext_clk),
        .rst_n_i        (rst_n_i),
        .reg_addr_i     (reg_addr_i),
        .reg_wdata_i    (reg_wdata_i),
        .reg_write_i    (reg_write_i),
        .reg_read_i     (reg_read_i),
        .reg_rdata_o    (reg_rdata_o),
        .usr_dip_i      (usr_dip_i),
        .sram_o         (sram_bus.ctrl),
        .led_o          (led_bus.ctrl)
    );

    sram_rwtest u_sram_rwtest (
        .ext_clk        (ext_clk),
        .rst_n_i        (rst_n_i),
        .test_i         (sram_bus.tester),
        .sram_addr_o    (sram_addr_o),
        .sram_wdata_o   (sram_wdata_o),
        .sram_rdata_i   (sram_rdata_i),
        .sram_cs_n_o    (sram_cs_n_o),
        .sram_we_n_o    (sram_we_n_o),
        .sram_oe_n_o    (sram_oe_n_o)
    );

    led_status u_led_status (
        .ext_clk        (ext_clk),
        .rst_n_i        (rst_n_i),
        .led_i          (led_bus.disp),
        .usr_led_o      (usr_led_o)
    );

endmodule

`default_nettype wire

/* verif/sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_model import cw_target_pkg::*; (
    input  sram_addr_t  addr_i,
    input  sram_data_t  wdata_i,
    output sram_data_t  rdata_o,
    input  logic        cs_n_i,
    input  logic        we_n_i,
    input  logic        oe_n_i,
    input  logic        fault_i     // sticks data bit 3 at 1
);

    sram_data_t mem [0:(1 << $bits(sram_addr_t))-1];

    // power-up contents differ from both test patterns
    initial begin
        for (int i = 0; i < (1 << $bits(sram_addr_t)); i++) begin
            mem[i] = {4'hc, sram_addr_t'(i)};
        end
    end

    // level-sensitive write while both strobes are low
    always @(*) begin
        if (!cs_n_i && !we_n_i) begin
            mem[addr_i] = wdata_i;
        end
    end

    assign rdata_o = (!cs_n_i && !oe_n_i) ? (mem[addr_i] | {12'h000, fault_i, 3'b000}) : '0;

endmodule

`default_nettype wire

/* verif/tb_cw_target.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cw_target_cfg.svh"

module tb_cw_target;

    logic                       ext_clk;
    logic                       rst_n_i;
    logic [`CW_REG_ADDR_W-1:0]  reg_addr;
    logic [`CW_REG_DATA_W-1:0]  reg_wdata;
    logic                       reg_write;
    logic                       reg_read;
    logic [`CW_REG_DATA_W-1:0]  reg_rdata;
    logic [7:0]                 usr_dip;
    logic [7:0]                 usr_led;
    logic [`CW_SRAM_ADDR_W-1:0] sram_addr;
    logic [`CW_SRAM_DATA_W-1:0] sram_wdata;
    logic [`CW_SRAM_DATA_W-1:0] sram_rdata;
    logic                       sram_cs_n;
    logic                       sram_we_n;
    logic                       sram_oe_n;
    logic                       fault;
    string                      line;
    string                      test_name;
    logic [7:0]                 cmd;
    logic [7:0]                 addr;
    logic [7:0]                 data;
    logic [7:0]                 rd;
    integer                     limit;
    integer                     fd;
    integer                     n;
    integer                     seed;
    integer                     rnd;
    integer                     checks;
    integer                     errors;

    cw_target_top dut (
        .ext_clk(ext_clk), .rst_n_i(rst_n_i),
        .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_write_i(reg_write),
        .reg_read_i(reg_read), .reg_rdata_o(reg_rdata),
        .usr_dip_i(usr_dip), .usr_led_o(usr_led),
        .sram_addr_o(sram_addr), .sram_wdata_o(sram_wdata), .sram_rdata_i(sram_rdata),
        .sram_cs_n_o(sram_cs_n), .sram_we_n_o(sram_we_n), .sram_oe_n_o(sram_oe_n)
    );

    sram_model u_sram (
        .addr_i(sram_addr), .wdata_i(sram_wdata), .rdata_o(sram_rdata),
        .cs_n_i(sram_cs_n), .we_n_i(sram_we_n), .oe_n_i(sram_oe_n), .fault_i(fault)
    );

    always #4 ext_clk = ~ext_clk;

    task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
        @(negedge ext_clk);
        reg_addr  = a;
        reg_wdata = d;
        reg_write = 1'b1;
        @(negedge ext_clk);
        reg_write = 1'b0;
    endtask

    // rdata is captured on the edge inside the strobe
    task automatic bus_read(input logic [7:0] a, output logic [7:0] d);
        @(negedge ext_clk);
        reg_addr = a;
        reg_read = 1'b1;
        @(negedge ext_clk);
        reg_read = 1'b0;
        d = reg_rdata;
    endtask

    task automatic check_value(input logic [7:0] exp, input logic [7:0] act);
        checks = checks + 1;
        assert (act == exp) else begin
            errors = errors + 1;
            $display("** Error %0s: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic poll_reg(input logic [7:0] a, input logic [7:0] exp, input integer max_reads);
        logic [7:0] val;
        integer     k;
        val = ~exp;
        k   = 0;
        while (val != exp && k < max_reads) begin
            bus_read(a, val);
            k = k + 1;
        end
        checks = checks + 1;
        assert (val == exp) else begin
            errors = errors + 1;
            $display("%0s: register %h did not reach %h within %0d reads",
                     test_name, a, exp, max_reads);
        end
    endtask

    // exp holds {cs_n, we_n, oe_n}
    // a running test strobes again within one word, so the level must hold
    task automatic wait_strobes(input logic [2:0] exp, input integer max_cycles);
        integer k;
        logic   held;
        k = 0;
        while ({sram_cs_n, sram_we_n, sram_oe_n} != exp && k < max_cycles) begin
            @(negedge ext_clk);
            k = k + 1;
        end
        held = ({sram_cs_n, sram_we_n, sram_oe_n} == exp);
        k    = 0;
        while (held && k < max_cycles) begin
            @(negedge ext_clk);
            held = ({sram_cs_n, sram_we_n, sram_oe_n} == exp);
            k    = k + 1;
        end
        checks = checks + 1;
        assert (held) else begin
            errors = errors + 1;
            $display("%0s: SRAM strobes did not settle at %b within %0d cycles",
                     test_name, exp, max_cycles);
        end
    endtask

    task automatic run_command;
        case (cmd)
            "W": begin
                // wait registers get a random value in 1..data and are read back
                if ((addr == `REG_SRAM_WWAIT || addr == `REG_SRAM_RWAIT) && data != 8'd0) begin
                    rnd  = $random(seed);
                    data = 8'((rnd & 32'h7fff_ffff) % data + 1);
                    bus_write(addr, data);
                    bus_read(addr, rd);
                    check_value(data, rd);
                end else begin
                    bus_write(addr, data);
                end
            end
            "R": begin
                bus_read(addr, rd);
                check_value(data, rd);
            end
            "P": poll_reg(addr, data, limit);
            "L": begin
                @(negedge ext_clk);
                check_value(data, usr_led & addr);      // addr column is the mask
            end
            "S": wait_strobes(data[2:0], limit);
            "F": fault = data[0];
            default: begin
                errors = errors + 1;
                $display("%0s: unknown command in golden file", test_name);
            end
        endcase
    endtask

    initial begin
        ext_clk   = 1'b0;
        rst_n_i   = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        reg_write = 1'b0;
        reg_read  = 1'b0;
        usr_dip   = 8'ha5;
        fault     = 1'b0;
        seed      = 14;
        checks    = 0;
        errors    = 0;
        repeat (8) @(posedge ext_clk);
        @(negedge ext_clk);
        rst_n_i = 1'b1;
        fd = $fopen("verif/cw_target_golden.txt", "r");
        if (fd == 0) begin
            errors = errors + 1;
            $display("could not open verif/cw_target_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin     // skip comment lines
                    if ($sscanf(line, "%s %s %h %h %d",
                                test_name, cmd, addr, data, limit) == 5) begin
                        run_command();
                    end
                end
            end
            $fclose(fd);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/cw_target_golden.txt */
# name cmd addr data limit, addr and data in hex, limit in decimal
# W write, R read, P poll, L leds masked by addr, S strobes {cs_n,we_n,oe_n}, F fault
id_read        R 00 41 0
dip_read       R 01 a5 0
unmapped_read  R 0a 00 0
leds_reset     L fe 00 0
test_leds_wr   W 03 5a 0
test_mode_on   W 02 01 0
test_leds_rd   R 03 5a 0
led_ctrl_rd    R 02 01 0
leds_test      L ff 5a 0
test_mode_off  W 02 00 0
sram_top_wr    W 05 01 0
sram_top_rd    R 05 01 0
wwait_rand     W 06 03 0
rwait_rand     W 07 03 0
sram_enable    W 04 01 0
ctrl_rd        R 04 01 0
pass_poll      P 08 01 400
runs_rd        R 09 01 0
leds_pass      L fe 06 0
sram_disable   W 04 00 0
strobes_idle   S 00 07 50
fault_on       F 00 01 0
fault_enable   W 04 01 0
fail_poll      P 08 02 400
leds_fail      L fe 0a 0
sram_stop      W 04 00 0
strobes_stop   S 00 07 50
fault_off      F 00 00 0
status_sticky  R 08 02 0
sram_restart   W 04 01 0
status_clear   R 08 00 0
pass_poll2     P 08 01 400

/* vlog.f */
+incdir+hdl
hdl/cw_target_pkg.sv
hdl/cw_target_ifs.sv
hdl/host_regs.sv
hdl/sram_rwtest.sv
hdl/led_status.sv
hdl/cw_target_top.sv
verif/sram_model.sv
verif/tb_cw_target.sv

/* Makefile */
TOP = tb_cw_target

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
